//--- hdl/adpcm_pkg.sv
package adpcm_pkg;

	// ====================
	// Address widths
	// ====================

	// Sample memory is 32 MB, byte addressed
	localparam int BYTE_ADDR_W = 25;
	// Memory port is 16 bits wide, so bit 0 selects the byte
	localparam int WORD_ADDR_W = BYTE_ADDR_W - 1;

	// ====================
	// Load index range
	// ====================

	// ROM indexes 16 to 63 carry the ADPCM sample images
	// Upper bound needs 7 bits since the index itself is only 6 bits
	localparam logic [6:0] INDEX_VROMS = 7'd16;
	localparam logic [6:0] INDEX_CROMS = 7'd64;

	// Each index step moves the load base by 512 KB
	localparam int VROM_SLOT_BITS = 19;

	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;

	// ====================
	// Latched read address
	// ====================

	// Channel A view: 16 banks of 1 MB in the low 16 MB
	typedef struct packed {
		logic        zero;
		logic [3:0]  bank;
		logic [19:0] offset;
	} sample_addr_a_t;

	// Channel B view: region bit picks the upper or lower 16 MB
	// Region is the inverse of use_pcm
	typedef struct packed {
		logic        region;
		logic [23:0] offset;
	} sample_addr_b_t;

	// One latch, decoded per channel
	typedef union packed {
		byte_addr_t     full;
		sample_addr_a_t a;
		sample_addr_b_t b;
	} sample_addr_u;

	// ====================
	// Memory handshakes
	// ====================

	// Toggle request: pending while toggle differs from the ack
	typedef struct packed {
		logic       toggle;
		word_addr_t addr;
	} mem_rd_req_t;

	// Data is valid in the cycle the ack catches up
	typedef struct packed {
		logic        ack;
		logic [15:0] data;
	} mem_rd_rsp_t;

	typedef struct packed {
		logic        toggle;
		word_addr_t  addr;
		logic [15:0] data;
	} mem_wr_req_t;

	// Host download bus
	typedef struct packed {
		logic        download;
		logic        wr;
		byte_addr_t  addr;
		logic [5:0]  index;
		logic [15:0] data;
	} ioctl_t;

endpackage

//--- hdl/adpcm_roe_detect.sv
module adpcm_roe_detect (
	input  logic clk_sys,
	input  logic nBNKB,
	// Output enable strobe from the sound chip, active low
	input  logic roe_n,
	// One-cycle grant from the arbiter
	input  logic take,
	output logic pend
);

	// Last two samples of roe_n, oldest in bit 1
	logic [1:0] roe_hist;
	// High-then-low pattern in the history
	logic       roe_fall;

	assign roe_fall = (roe_hist == 2'b10);

	// ====================
	// Edge history
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			// Strobe idles high, so start from the idle pattern
			roe_hist <= 2'b11;
		end
		else
		begin
			roe_hist <= {roe_hist[0], roe_n};
		end
	end

	// ====================
	// Pending request
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			pend <= 1'b0;
		end
		else if (roe_fall)
		begin
			// New edge wins over a take in the same cycle
			// Edges while already pending merge into one request
			pend <= 1'b1;
		end
		else if (take)
		begin
			pend <= 1'b0;
		end
	end

endmodule

//--- hdl/adpcm_read_arbiter.sv
module adpcm_read_arbiter (
	input  logic                   clk_sys,
	input  logic                   nBNKB,
	// Pending strobes from the two edge detectors
	input  logic                   pend_a,
	input  logic                   pend_b,
	output logic                   take_a,
	output logic                   take_b,
	// Sample address sources
	input  logic                   use_pcm,
	input  logic [3:0]             adpcma_bank,
	input  logic [19:0]            adpcma_addr,
	input  logic [23:0]            adpcmb_addr,
	// Memory read port
	output adpcm_pkg::mem_rd_req_t rd_req,
	input  adpcm_pkg::mem_rd_rsp_t rd_rsp,
	// Byte registers read back by the sound chip
	output logic [7:0]             adpcma_data,
	output logic [7:0]             adpcmb_data
);

	import adpcm_pkg::*;

	// Request toggle that is pending while it differs from the ack
	logic         rd_toggle;
	// Channel that owns the outstanding read
	logic         wait_a;
	logic         wait_b;
	logic         busy;
	logic         grant_a;
	logic         grant_b;
	logic         rd_done;
	// Address of the outstanding read
	sample_addr_u addr_q;
	// Byte picked out of the returned word
	logic [7:0]   ret_byte;

	// ====================
	// Grant
	// ====================

	assign busy = wait_a | wait_b;

	// B goes first since it may run faster than A
	assign grant_b = pend_b & ~busy;
	assign grant_a = pend_a & ~pend_b & ~busy;

	assign take_a = grant_a;
	assign take_b = grant_b;

	// Ack has caught up with the request
	assign rd_done = busy & (rd_toggle == rd_rsp.ack);

	// Odd byte address reads the high half
	assign ret_byte = addr_q.full[0] ? rd_rsp.data[15:8] : rd_rsp.data[7:0];

	// Word address drops the byte select
	assign rd_req = '{toggle: rd_toggle, addr: addr_q.full[BYTE_ADDR_W-1:1]};

	// ====================
	// Handshake state
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			rd_toggle <= 1'b0;
			wait_a <= 1'b0;
			wait_b <= 1'b0;
		end
		else
		begin
			// Launch a read by moving away from the ack
			if (grant_a | grant_b)
			begin
				rd_toggle <= ~rd_rsp.ack;
			end

			if (grant_b)
			begin
				wait_b <= 1'b1;
			end
			else if (grant_a)
			begin
				wait_a <= 1'b1;
			end

			// Only one owner at a time so both clear together
			if (rd_done)
			begin
				wait_a <= 1'b0;
				wait_b <= 1'b0;
			end
		end
	end

	// Address latch, held steady until the read completes
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			addr_q.full <= '0;
		end
		else if (grant_b)
		begin
			addr_q.b <= '{region: ~use_pcm, offset: adpcmb_addr};
		end
		else if (grant_a)
		begin
			addr_q.a <= '{zero: 1'b0, bank: adpcma_bank, offset: adpcma_addr};
		end
	end

	// ====================
	// Return steering
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			adpcma_data <= 8'h00;
			adpcmb_data <= 8'h00;
		end
		else if (rd_done)
		begin
			if (wait_a)
			begin
				adpcma_data <= ret_byte;
			end
			if (wait_b)
			begin
				adpcmb_data <= ret_byte;
			end
		end
	end

endmodule

//--- hdl/adpcm_load_writer.sv
module adpcm_load_writer (
	input  logic                   clk_sys,
	input  logic                   nBNKB,
	// Host download bus
	input  adpcm_pkg::ioctl_t      ioctl,
	output logic                   ioctl_wait,
	// Memory write port
	output adpcm_pkg::mem_wr_req_t wr_req,
	input  logic                   we_ack
);

	import adpcm_pkg::*;

	logic        loading;
	logic        loading_q;
	logic        load_start;
	// Sample slot counted from the first sample index
	logic [5:0]  slot;
	byte_addr_t  load_addr;
	logic        wr_toggle;
	word_addr_t  wr_addr;
	logic [15:0] wr_data;

	// ====================
	// Address mapping
	// ====================

	// Only sample ROM indexes go to this memory
	assign loading = ioctl.download
		& ({1'b0, ioctl.index} >= INDEX_VROMS)
		& ({1'b0, ioctl.index} < INDEX_CROMS);
	assign load_start = loading & ~loading_q;

	// 512 KB per index step
	assign slot = ioctl.index - INDEX_VROMS[5:0];
	assign load_addr = ioctl.addr + (byte_addr_t'(slot) << VROM_SLOT_BITS);

	assign wr_req = '{toggle: wr_toggle, addr: wr_addr, data: wr_data};

	// ====================
	// Write handshake
	// ====================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			loading_q <= 1'b0;
			wr_toggle <= 1'b0;
			ioctl_wait <= 1'b0;
		end
		else
		begin
			loading_q <= loading;
			if (loading & ioctl.wr)
			begin
				// A write in the first loading cycle flips from the cleared value
				wr_toggle <= load_start ? 1'b1 : ~wr_toggle;
				ioctl_wait <= 1'b1;
			end
			else if (load_start)
			begin
				wr_toggle <= 1'b0;
			end
			else if (ioctl_wait & (wr_toggle == we_ack))
			begin
				// Host may send the next word
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word and data held for the memory until the ack
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			wr_addr <= '0;
			wr_data <= 16'h0000;
		end
		else if (loading & ioctl.wr)
		begin
			wr_addr <= load_addr[BYTE_ADDR_W-1:1];
			wr_data <= ioctl.data;
		end
	end

endmodule

//--- hdl/adpcm_fetch.sv
module adpcm_fetch (
	input  logic                   clk_sys,
	input  logic                   nBNKB,
	// Sound chip side
	input  logic                   use_pcm,
	input  logic                   adpcma_roe_n,
	input  logic                   adpcmb_roe_n,
	input  logic [3:0]             adpcma_bank,
	input  logic [19:0]            adpcma_addr,
	input  logic [23:0]            adpcmb_addr,
	output logic [7:0]             adpcma_data,
	output logic [7:0]             adpcmb_data,
	// Host download side
	input  adpcm_pkg::ioctl_t      ioctl,
	output logic                   ioctl_wait,
	// External sample memory
	output adpcm_pkg::mem_rd_req_t rd_req,
	input  adpcm_pkg::mem_rd_rsp_t rd_rsp,
	output adpcm_pkg::mem_wr_req_t wr_req,
	input  logic                   we_ack
);

	// Pending strobes and their grants
	logic pend_a;
	logic pend_b;
	logic take_a;
	logic take_b;

	// ====================
	// Strobe edge detect
	// ====================

	adpcm_roe_detect roe_a_inst (
		.clk_sys (clk_sys),
		.nBNKB   (nBNKB),
		.roe_n   (adpcma_roe_n),
		.take    (take_a),
		.pend    (pend_a)
	);

	adpcm_roe_detect roe_b_inst (
		.clk_sys (clk_sys),
		.nBNKB   (nBNKB),
		.roe_n   (adpcmb_roe_n),
		.take    (take_b),
		.pend    (pend_b)
	);

	// Read path, one outstanding read shared by both channels
	adpcm_read_arbiter arbiter_inst (
		.clk_sys     (clk_sys),
		.nBNKB       (nBNKB),
		.pend_a      (pend_a),
		.pend_b      (pend_b),
		.take_a      (take_a),
		.take_b      (take_b),
		.use_pcm     (use_pcm),
		.adpcma_bank (adpcma_bank),
		.adpcma_addr (adpcma_addr),
		.adpcmb_addr (adpcmb_addr),
		.rd_req      (rd_req),
		.rd_rsp      (rd_rsp),
		.adpcma_data (adpcma_data),
		.adpcmb_data (adpcmb_data)
	);

	// ====================
	// Sample ROM loader
	// ====================

	adpcm_load_writer writer_inst (
		.clk_sys    (clk_sys),
		.nBNKB      (nBNKB),
		.ioctl      (ioctl),
		.ioctl_wait (ioctl_wait),
		.wr_req     (wr_req),
		.we_ack     (we_ack)
	);

endmodule

//--- dv/adpcm_fetch_assert.sv
module adpcm_fetch_assert (
	input logic                   clk_sys,
	input logic                   nBNKB,
	input adpcm_pkg::mem_rd_req_t rd_req,
	input adpcm_pkg::mem_rd_rsp_t rd_rsp,
	input adpcm_pkg::mem_wr_req_t wr_req,
	input logic                   we_ack,
	input logic                   ioctl_wait
);
	timeunit 1ns;
	timeprecision 100ps;

	logic rd_busy;
	logic wr_busy;

	// Outstanding while the toggle leads the ack
	assign rd_busy = (rd_req.toggle != rd_rsp.ack);
	assign wr_busy = (wr_req.toggle != we_ack);

	// ====================
	// Read handshake
	// ====================

	// Address held from the cycle after launch until completion
	rd_addr_stable: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		rd_busy && $past(rd_busy) |-> $stable(rd_req.addr))
		else $error("read address moved during an outstanding read");

	// No second launch over an open read
	rd_toggle_held: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		rd_busy |=> $stable(rd_req.toggle))
		else $error("read toggle flipped during an outstanding read");

	// Host stalled for every open write
	wr_wait_high: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		wr_busy |-> ioctl_wait)
		else $error("ioctl_wait low during an outstanding write");

endmodule

//--- dv/adpcm_fetch_tb.sv
module adpcm_fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import adpcm_pkg::*;

	logic         clk_sys;
	logic         nBNKB;
	logic         use_pcm;
	logic         adpcma_roe_n;
	logic         adpcmb_roe_n;
	logic [3:0]   adpcma_bank;
	logic [19:0]  adpcma_addr;
	logic [23:0]  adpcmb_addr;
	logic [7:0]   adpcma_data;
	logic [7:0]   adpcmb_data;
	ioctl_t       ioctl;
	logic         ioctl_wait;
	mem_rd_req_t  rd_req;
	mem_rd_rsp_t  rd_rsp;
	mem_wr_req_t  wr_req;
	logic         we_ack;

	// Memory model contents and the host side copy of the loaded words
	logic [15:0]  mem [word_addr_t];
	logic [15:0]  shadow [word_addr_t];
	word_addr_t   rd_log [$];
	int           rd_cnt = 0;
	int           force_delay = 0;
	logic [31:0]  lcg_state = 32'hacbb;
	int           errors = 0;
	int           checks = 0;
	int           tests = 0;
	int           test_err = 0;
	bit           timeout_hit = 0;
	// Pending comparisons for the compare process
	bit           exp_chan_q [$];
	logic [7:0]   exp_val_q [$];

	adpcm_fetch adpcm_fetch_inst (.*);

	bind adpcm_fetch adpcm_fetch_assert adpcm_fetch_assert_inst (.*);

	// ====================
	// Helpers
	// ====================

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:8];
	endfunction

	// Unloaded words get a pattern built from every address bit
	function automatic logic [15:0] fill_word(input word_addr_t w);
		return w[15:0] ^ {w[23:16], w[23:16]} ^ 16'h5a3c;
	endfunction

	function automatic int mem_delay();
		return (force_delay != 0) ? force_delay : 1 + (lcg_next() % 8);
	endfunction

	// Load base moves 512 KB per index above 16
	function automatic word_addr_t load_word(input logic [5:0] index, input logic [24:0] addr);
		logic [24:0] b;
		b = addr + ((25'(index) - 25'd16) << 19);
		return b[24:1];
	endfunction

	// Reference byte from zero, bank and offset on A or region and offset on B
	function automatic logic [7:0] expected_byte(input bit chan_b, input logic [3:0] bank,
		input logic [23:0] addr, input logic pcm);
		logic [24:0] b;
		word_addr_t  w;
		logic [15:0] word;
		if (chan_b)
			b = {~pcm, addr};
		else
			b = {1'b0, bank, addr[19:0]};
		w = b[24:1];
		word = shadow.exists(w) ? shadow[w] : fill_word(w);
		return b[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Halts the calling stimulus until the end process stops the run
	task automatic timeout_stop(input string what);
		$display("Timed out waiting for %s", what);
		timeout_hit = 1;
		forever @(posedge clk_sys);
	endtask

	task automatic wait_reads(input int target);
		int t;
		t = 0;
		while (rd_cnt < target)
		begin
			@(posedge clk_sys);
			t++;
			if (t > 100)
				timeout_stop("memory read completion");
		end
	endtask

	task automatic wait_outstanding();
		int t;
		t = 0;
		while (rd_req.toggle == rd_rsp.ack)
		begin
			@(posedge clk_sys);
			t++;
			if (t > 50)
				timeout_stop("read request launch");
		end
	endtask

	task automatic wait_host_ready();
		int t;
		t = 0;
		while (ioctl_wait)
		begin
			@(posedge clk_sys);
			t++;
			if (t > 50)
				timeout_stop("ioctl_wait to fall");
		end
	endtask

	// Queue a comparison and let the compare process take it
	task automatic expect_data(input bit chan_b, input logic [7:0] val);
		int t;
		t = 0;
		repeat (2) @(posedge clk_sys);
		exp_chan_q.push_back(chan_b);
		exp_val_q.push_back(val);
		while (exp_val_q.size() > 0)
		begin
			@(posedge clk_sys);
			t++;
			if (t > 10)
				timeout_stop("compare process");
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_err) ? "ok" : "failed");
		test_err = errors;
	endtask

	task automatic host_write(input logic [5:0] index, input logic [24:0] addr);
		logic [15:0] d;
		d = lcg_next();
		wait_host_ready();
		@(posedge clk_sys);
		ioctl.index <= index;
		ioctl.addr <= addr;
		ioctl.data <= d;
		ioctl.wr <= 1'b1;
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
		@(negedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, 1);
		shadow[load_word(index, addr)] = d;
		wait_host_ready();
	endtask

	// One strobe fall on a channel and a compare once the read returns
	task automatic fetch(input bit chan_b, input logic [3:0] bank, input logic [23:0] addr,
		input logic pcm);
		int target;
		target = rd_cnt + 1;
		@(posedge clk_sys);
		use_pcm <= pcm;
		if (chan_b)
		begin
			adpcmb_addr <= addr;
			adpcmb_roe_n <= 1'b0;
		end
		else
		begin
			adpcma_bank <= bank;
			adpcma_addr <= addr[19:0];
			adpcma_roe_n <= 1'b0;
		end
		@(posedge clk_sys);
		adpcma_roe_n <= 1'b1;
		adpcmb_roe_n <= 1'b1;
		wait_reads(target);
		expect_data(chan_b, expected_byte(chan_b, bank, addr, pcm));
	endtask

	// ====================
	// Clock and models
	// ====================

	initial
	begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Read side with ack and data landing together after the delay
	initial
	begin : read_model
		int d;
		rd_rsp = '0;
		forever
		begin
			@(posedge clk_sys);
			if (nBNKB && (rd_req.toggle != rd_rsp.ack))
			begin
				d = mem_delay();
				repeat (d - 1) @(posedge clk_sys);
				rd_rsp.data <= mem.exists(rd_req.addr) ? mem[rd_req.addr] : fill_word(rd_req.addr);
				rd_rsp.ack <= rd_req.toggle;
				rd_log.push_back(rd_req.addr);
				rd_cnt++;
			end
		end
	end

	initial
	begin : write_model
		int d;
		we_ack = 1'b0;
		forever
		begin
			@(posedge clk_sys);
			if (nBNKB && (wr_req.toggle != we_ack))
			begin
				d = mem_delay();
				repeat (d - 1) @(posedge clk_sys);
				mem[wr_req.addr] = wr_req.data;
				we_ack <= wr_req.toggle;
			end
		end
	end

	// Compares queued expectations where outputs are stable
	initial
	begin : compare
		forever
		begin
			@(negedge clk_sys);
			while (exp_val_q.size() > 0)
			begin
				if (exp_chan_q.pop_front())
					check_value("adpcmb_data", adpcmb_data, exp_val_q.pop_front());
				else
					check_value("adpcma_data", adpcma_data, exp_val_q.pop_front());
			end
		end
	end

	initial
	begin : timeout_end
		wait (timeout_hit);
		$display("** FAIL **");
		$finish;
	end

	// ====================
	// Stimulus
	// ====================

	initial
	begin : stimulus
		int base;
		int log_base;
		nBNKB = 1'b0;
		use_pcm = 1'b0;
		adpcma_roe_n = 1'b1;
		adpcmb_roe_n = 1'b1;
		adpcma_bank = '0;
		adpcma_addr = '0;
		adpcmb_addr = '0;
		ioctl = '0;
		repeat (5) @(posedge clk_sys);
		nBNKB <= 1'b1;

		@(negedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("rd_req.toggle", rd_req.toggle, 0);
		check_value("wr_req.toggle", wr_req.toggle, 0);
		check_value("adpcma_data", adpcma_data, 0);
		check_value("adpcmb_data", adpcmb_data, 0);
		end_test("reset");

		// Download stays high so the index can move without a restart
		@(posedge clk_sys);
		ioctl.download <= 1'b1;
		ioctl.index <= 6'd16;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < 4; i++)
		begin
			host_write(6'd16, 25'h10 + 25'(2 * i));
			host_write(6'd17, 25'h100 + 25'(2 * i));
			host_write(6'd40, 25'h2000 + 25'(2 * i));
		end
		@(posedge clk_sys);
		ioctl.download <= 1'b0;
		foreach (shadow[w])
			check_value("mem", mem.exists(w) ? 32'(mem[w]) : 'x, shadow[w]);
		end_test("load");

		fetch(0, 4'd0, 24'h10, 0);
		fetch(0, 4'd0, 24'h13, 0);
		fetch(0, 4'd0, 24'h80101, 0);
		fetch(0, 4'd12, 24'h2002, 0);
		fetch(0, 4'd5, 24'h3_1235, 0);
		end_test("channel A fetch");

		fetch(1, 4'd0, 24'hc02003, 1);
		fetch(1, 4'd0, 24'hc02004, 0);
		fetch(1, 4'd0, 24'h080103, 1);
		end_test("channel B fetch");

		// Same cycle fall on both strobes with a slow memory
		force_delay = 8;
		base = rd_cnt;
		log_base = rd_log.size();
		@(posedge clk_sys);
		use_pcm <= 1'b1;
		adpcma_bank <= 4'd0;
		adpcma_addr <= 20'h11;
		adpcmb_addr <= 24'hc02005;
		adpcma_roe_n <= 1'b0;
		adpcmb_roe_n <= 1'b0;
		@(posedge clk_sys);
		adpcma_roe_n <= 1'b1;
		adpcmb_roe_n <= 1'b1;
		wait_reads(base + 2);
		check_value("first read addr", rd_log[log_base], 24'h601002);
		check_value("second read addr", rd_log[log_base + 1], 24'h000008);
		expect_data(0, expected_byte(0, 4'd0, 24'h11, 1));
		expect_data(1, expected_byte(1, 4'd0, 24'hc02005, 1));
		end_test("priority");

		// Two more A edges while its first read is still in flight
		base = rd_cnt;
		@(posedge clk_sys);
		adpcma_addr <= 20'h80102;
		adpcma_roe_n <= 1'b0;
		@(posedge clk_sys);
		adpcma_roe_n <= 1'b1;
		wait_outstanding();
		@(posedge clk_sys);
		adpcma_bank <= 4'd12;
		adpcma_addr <= 20'h2005;
		adpcma_roe_n <= 1'b0;
		@(posedge clk_sys);
		adpcma_roe_n <= 1'b1;
		// Lands while the previous edge is still pending
		@(posedge clk_sys);
		adpcma_addr <= 20'h2007;
		adpcma_roe_n <= 1'b0;
		@(posedge clk_sys);
		adpcma_roe_n <= 1'b1;
		wait_reads(base + 2);
		repeat (20) @(posedge clk_sys);
		check_value("read count", rd_cnt - base, 2);
		expect_data(0, expected_byte(0, 4'd12, 24'h2007, 1));
		end_test("merge");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- vlog.f
hdl/adpcm_pkg.sv
hdl/adpcm_roe_detect.sv
hdl/adpcm_read_arbiter.sv
hdl/adpcm_load_writer.sv
hdl/adpcm_fetch.sv
dv/adpcm_fetch_assert.sv
dv/adpcm_fetch_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f vlog.f --top-module adpcm_fetch_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
